// ==== design/vdp_pkg.sv ====
// Shared VDP types and constants; line counts are for the scan-doubled output, so one display line spans two output lines
`default_nettype none

package vdp_pkg;

  // --------------------
  // Vector types
  // --------------------

  // Scan coordinate from the external video timing
  typedef logic [9:0] coord_t;

  // Display line number, also the R19 compare value
  typedef logic [7:0] line_t;

  typedef logic [7:0] cpu_data_t;

  // Register number carried in the second control byte
  typedef logic [5:0] reg_num_t;

  // Color channel widths, internal and at the output
  typedef logic [5:0] color6_t;
  typedef logic [7:0] color8_t;

  // Control port byte sequence
  typedef enum logic {
    CTL_FIRST,
    CTL_SECOND
  } ctl_state_t;

  // --------------------
  // Output lines per frame
  // --------------------
  localparam coord_t LINES_NTSC    = 10'd524;
  localparam coord_t LINES_PAL     = 10'd626;
  localparam coord_t LINES_NTSC_IL = 10'd525;
  localparam coord_t LINES_PAL_IL  = 10'd625;

  // --------------------
  // Register numbers kept by this core
  // --------------------
  localparam reg_num_t REG_HSYNC_EN   = 6'd0;
  localparam reg_num_t REG_VSYNC_EN   = 6'd1;
  localparam reg_num_t REG_FRAME_COL  = 6'd7;
  localparam reg_num_t REG_STD        = 6'd9;
  localparam reg_num_t REG_STATUS_PTR = 6'd15;
  localparam reg_num_t REG_HSYNC_LINE = 6'd19;

endpackage

`default_nettype wire

// ==== design/vdp_frame_timing.sv ====
// Needs cx/cy from an external scan generator; the window opens only at cy == V_BORDER, with no reopen for the second field
`default_nettype none

module vdp_frame_timing
  import vdp_pkg::*;
#(
  parameter int V_BORDER     = 40,
  parameter int ACTIVE_LINES = 192
) (
  input  logic   reset,
  input  logic   clk21m,
  input  coord_t cx,
  input  coord_t cy,
  input  logic   pal_mode,
  input  logic   interlace,
  input  line_t  hsync_line,
  output logic   window_y,
  output logic   vblank_start,
  output logic   hsync_line_hit
);

  // Output line where the window opens
  localparam coord_t BORDER_LINE = coord_t'(V_BORDER);

  // First output line below the active area, two output lines per display line
  localparam coord_t VBLANK_LINE = coord_t'(V_BORDER + 2 * ACTIVE_LINES);

  coord_t frame_lines;
  coord_t border_offset;
  line_t  disp_line;
  logic   line_start;

  // --------------------
  // Frame length
  // --------------------

  // Interlace adds or drops one line depending on the standard
  always_comb begin
    case ({interlace, pal_mode})
      2'b00:   frame_lines = LINES_NTSC;
      2'b01:   frame_lines = LINES_PAL;
      2'b10:   frame_lines = LINES_NTSC_IL;
      default: frame_lines = LINES_PAL_IL;
    endcase
  end

  // --------------------
  // Display line number
  // --------------------

  // Offset from the top border, halved to get the display line
  assign border_offset = cy - BORDER_LINE;
  assign disp_line     = border_offset[8:1];

  assign line_start = (cx == '0);

  // --------------------
  // Vertical window
  // --------------------
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      window_y <= 1'b0;
    end else if (cy == BORDER_LINE) begin
      window_y <= 1'b1;
    end else if ((cy == '0) || (cy == frame_lines)) begin
      // Closes at the frame wrap and at the standard's line count
      window_y <= 1'b0;
    end
  end

  // --------------------
  // Frame events
  // --------------------

  // Both events are sampled at the start of a line and last one clock
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      vblank_start   <= 1'b0;
      hsync_line_hit <= 1'b0;
    end else begin
      vblank_start   <= line_start && (cy == VBLANK_LINE);
      // Even output lines only, so each display line fires once
      hsync_line_hit <= line_start && !cy[0] && window_y &&
                        (disp_line == hsync_line);
    end
  end

endmodule

`default_nettype wire

// ==== design/vdp_registers.sv ====
// Control port 1 only; bit positions follow the V9938 (R0 bit 4, R1 bit 5, R9 bits 1 and 3), other registers are ignored
`default_nettype none

module vdp_registers
  import vdp_pkg::*;
(
  input  logic      reset,
  input  logic      clk21m,
  input  logic      req,
  input  logic      wrt,
  input  logic [1:0] mode,
  input  cpu_data_t dbo,
  input  logic      vsync_pending,
  input  logic      hsync_pending,
  output logic      ack,
  output cpu_data_t dbi,
  output logic      hsync_int_en,
  output logic      vsync_int_en,
  output cpu_data_t frame_col,
  output logic      pal_mode,
  output logic      interlace,
  output line_t     hsync_line,
  output logic      clr_vsync,
  output logic      clr_hsync
);

  ctl_state_t ctl_state;
  cpu_data_t  ctl_data;
  logic [3:0] status_ptr;
  logic       port1_wr;
  logic       port1_rd;
  logic       reg_wr;
  reg_num_t   reg_num;
  cpu_data_t  status_byte;

  // --------------------
  // Access decode
  // --------------------
  assign port1_wr = req && wrt && (mode == 2'b01);
  assign port1_rd = req && !wrt && (mode == 2'b01);

  // Second byte with bit 7 set carries the register number
  assign reg_num = dbo[5:0];
  assign reg_wr  = port1_wr && (ctl_state == CTL_SECOND) && dbo[7];

  // Status byte selected by R15
  always_comb begin
    case (status_ptr)
      4'd0:    status_byte = {vsync_pending, 7'b0000000};
      4'd1:    status_byte = {7'b0000000, hsync_pending};
      default: status_byte = '0;
    endcase
  end

  // --------------------
  // CPU handshake
  // --------------------

  // Every request is served, ack follows one clock later
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      ack       <= 1'b0;
      dbi       <= '0;
      clr_vsync <= 1'b0;
      clr_hsync <= 1'b0;
    end else begin
      ack       <= req;
      // Flag clear lands with ack, the interrupt block drops it a clock later
      clr_vsync <= port1_rd && (status_ptr == 4'd0);
      clr_hsync <= port1_rd && (status_ptr == 4'd1);
      if (port1_rd) begin
        dbi <= status_byte;
      end
    end
  end

  // --------------------
  // Two-byte write sequence
  // --------------------
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      ctl_state <= CTL_FIRST;
      ctl_data  <= '0;
    end else if (port1_rd) begin
      // A status read restarts the sequence
      ctl_state <= CTL_FIRST;
    end else if (port1_wr) begin
      case (ctl_state)
        CTL_FIRST: begin
          ctl_data  <= dbo;
          ctl_state <= CTL_SECOND;
        end
        default: begin
          ctl_state <= CTL_FIRST;
        end
      endcase
    end
  end

  // --------------------
  // Register file
  // --------------------
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      hsync_int_en <= 1'b0;
      vsync_int_en <= 1'b0;
      frame_col    <= '0;
      pal_mode     <= 1'b0;
      interlace    <= 1'b0;
      status_ptr   <= '0;
      hsync_line   <= '0;
    end else if (reg_wr) begin
      case (reg_num)
        REG_HSYNC_EN:   hsync_int_en <= ctl_data[4];
        REG_VSYNC_EN:   vsync_int_en <= ctl_data[5];
        REG_FRAME_COL:  frame_col    <= ctl_data;
        REG_STD: begin
          interlace <= ctl_data[3];
          pal_mode  <= ctl_data[1];
        end
        REG_STATUS_PTR: status_ptr   <= ctl_data[3:0];
        REG_HSYNC_LINE: hsync_line   <= ctl_data;
        default: begin
          // Dropped registers, write is discarded
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/vdp_interrupt.sv ====
// Pending flags are sticky until a status read; int_n is combinational from the flags and the enables
`default_nettype none

module vdp_interrupt
  import vdp_pkg::*;
(
  input  logic reset,
  input  logic clk21m,
  input  logic vblank_start,
  input  logic hsync_line_hit,
  input  logic clr_vsync,
  input  logic clr_hsync,
  input  logic vsync_int_en,
  input  logic hsync_int_en,
  output logic vsync_pending,
  output logic hsync_pending,
  output logic int_n
);

  logic vsync_req;
  logic hsync_req;

  // --------------------
  // Pending flags
  // --------------------

  // A new event wins over a clear in the same clock
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      vsync_pending <= 1'b0;
      hsync_pending <= 1'b0;
    end else begin
      if (vblank_start) begin
        vsync_pending <= 1'b1;
      end else if (clr_vsync) begin
        vsync_pending <= 1'b0;
      end

      if (hsync_line_hit) begin
        hsync_pending <= 1'b1;
      end else if (clr_hsync) begin
        hsync_pending <= 1'b0;
      end
    end
  end

  // --------------------
  // Interrupt line
  // --------------------

  // Disabled flags still set and stay readable
  assign vsync_req = vsync_pending && vsync_int_en;
  assign hsync_req = hsync_pending && hsync_int_en;

  assign int_n = !(vsync_req || hsync_req);

endmodule

`default_nettype wire

// ==== design/vdp_color_out.sv ====
// Pixel input must already be a 6-bit color; no palette, output is purely combinational
`default_nettype none

module vdp_color_out
  import vdp_pkg::*;
(
  input  logic      window_y,
  input  cpu_data_t frame_col,
  input  color6_t   pixel_r,
  input  color6_t   pixel_g,
  input  color6_t   pixel_b,
  input  logic      scanline,
  input  coord_t    cy,
  output color8_t   red,
  output color8_t   green,
  output color8_t   blue
);

  color6_t border_r;
  color6_t border_g;
  color6_t border_b;
  color6_t sel_r;
  color6_t sel_g;
  color6_t sel_b;
  logic    dim;

  // Widen to 8 bits, or halve when the line is dimmed
  function automatic color8_t expand(input color6_t c, input logic half);
    color8_t result;
    if (half) begin
      result = {1'b0, c, 1'b0};
    end else begin
      result = {c, 2'b00};
    end
    return result;
  endfunction

  // --------------------
  // Frame color decode
  // --------------------

  // R7 packs GGGRRRBB, each field repeated up to 6 bits
  assign border_g = {frame_col[7:5], frame_col[7:5]};
  assign border_r = {frame_col[4:2], frame_col[4:2]};
  assign border_b = {frame_col[1:0], frame_col[1:0], frame_col[1:0]};

  assign sel_r = window_y ? pixel_r : border_r;
  assign sel_g = window_y ? pixel_g : border_g;
  assign sel_b = window_y ? pixel_b : border_b;

  // Odd output lines are the dimmed ones
  assign dim = scanline && cy[0];

  assign red   = expand(sel_r, dim);
  assign green = expand(sel_g, dim);
  assign blue  = expand(sel_b, dim);

endmodule

`default_nettype wire

// ==== design/vdp_top.sv ====
// Frame control path only; no VRAM, no data port, the pixel input replaces the color decoder
`default_nettype none

module vdp_top
  import vdp_pkg::*;
#(
  parameter int V_BORDER     = 40,
  parameter int ACTIVE_LINES = 192
) (
  input  logic       reset,
  input  logic       clk21m,
  input  logic       req,
  input  logic       wrt,
  input  logic [1:0] mode,
  input  cpu_data_t  dbo,
  input  coord_t     cx,
  input  coord_t     cy,
  input  color6_t    pixel_r,
  input  color6_t    pixel_g,
  input  color6_t    pixel_b,
  input  logic       scanline,
  output logic       ack,
  output cpu_data_t  dbi,
  output logic       int_n,
  output color8_t    red,
  output color8_t    green,
  output color8_t    blue
);

  // Register levels
  logic      hsync_int_en;
  logic      vsync_int_en;
  cpu_data_t frame_col;
  logic      pal_mode;
  logic      interlace;
  line_t     hsync_line;

  // Status read clears
  logic      clr_vsync;
  logic      clr_hsync;

  // Frame timing results
  logic      window_y;
  logic      vblank_start;
  logic      hsync_line_hit;

  logic      vsync_pending;
  logic      hsync_pending;

  // --------------------
  // Timing and registers
  // --------------------
  vdp_frame_timing #(
    .V_BORDER     (V_BORDER),
    .ACTIVE_LINES (ACTIVE_LINES)
  ) u_frame_timing (
    .reset          (reset),
    .clk21m         (clk21m),
    .cx             (cx),
    .cy             (cy),
    .pal_mode       (pal_mode),
    .interlace      (interlace),
    .hsync_line     (hsync_line),
    .window_y       (window_y),
    .vblank_start   (vblank_start),
    .hsync_line_hit (hsync_line_hit)
  );

  vdp_registers u_registers (
    .reset         (reset),
    .clk21m        (clk21m),
    .req           (req),
    .wrt           (wrt),
    .mode          (mode),
    .dbo           (dbo),
    .vsync_pending (vsync_pending),
    .hsync_pending (hsync_pending),
    .ack           (ack),
    .dbi           (dbi),
    .hsync_int_en  (hsync_int_en),
    .vsync_int_en  (vsync_int_en),
    .frame_col     (frame_col),
    .pal_mode      (pal_mode),
    .interlace     (interlace),
    .hsync_line    (hsync_line),
    .clr_vsync     (clr_vsync),
    .clr_hsync     (clr_hsync)
  );

  // --------------------
  // Interrupt and video out
  // --------------------
  vdp_interrupt u_interrupt (
    .reset          (reset),
    .clk21m         (clk21m),
    .vblank_start   (vblank_start),
    .hsync_line_hit (hsync_line_hit),
    .clr_vsync      (clr_vsync),
    .clr_hsync      (clr_hsync),
    .vsync_int_en   (vsync_int_en),
    .hsync_int_en   (hsync_int_en),
    .vsync_pending  (vsync_pending),
    .hsync_pending  (hsync_pending),
    .int_n          (int_n)
  );

  vdp_color_out u_color_out (
    .window_y  (window_y),
    .frame_col (frame_col),
    .pixel_r   (pixel_r),
    .pixel_g   (pixel_g),
    .pixel_b   (pixel_b),
    .scanline  (scanline),
    .cy        (cy),
    .red       (red),
    .green     (green),
    .blue      (blue)
  );

endmodule

`default_nettype wire

// ==== verif/tb_vdp.sv ====
// Runs from verif/vdp_testdata.txt relative to the project root; assumes the default V_BORDER and ACTIVE_LINES
`default_nettype none

module tb_vdp
  import vdp_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int FIELDS          = 6;
  localparam int MAX_STEPS       = 64;
  localparam int ACK_LIMIT       = 4;
  localparam int CYCLES_PER_STEP = 20;

  // Clock is reset, asynchronous reset is clk21m
  logic       reset;
  logic       clk21m;
  logic       req;
  logic       wrt;
  logic [1:0] mode;
  cpu_data_t  dbo;
  coord_t     cx;
  coord_t     cy;
  color6_t    pixel_r;
  color6_t    pixel_g;
  color6_t    pixel_b;
  logic       scanline;
  logic       ack;
  cpu_data_t  dbi;
  logic       int_n;
  color8_t    red;
  color8_t    green;
  color8_t    blue;

  // Six hex words per step
  logic [15:0] step_mem [0:MAX_STEPS*FIELDS-1];
  int          num_steps;
  logic        load_done;
  integer      seed;
  cpu_data_t   r7_model;
  int          check_count;
  int          error_count;
  int          test_checks;
  int          test_errors;
  int          tests_done;

  vdp_top i_dut (
    .reset    (reset),
    .clk21m   (clk21m),
    .req      (req),
    .wrt      (wrt),
    .mode     (mode),
    .dbo      (dbo),
    .cx       (cx),
    .cy       (cy),
    .pixel_r  (pixel_r),
    .pixel_g  (pixel_g),
    .pixel_b  (pixel_b),
    .scanline (scanline),
    .ack      (ack),
    .dbi      (dbi),
    .int_n    (int_n),
    .red      (red),
    .green    (green),
    .blue     (blue)
  );

  initial begin
    reset = 1'b0;
    forever #2 reset = ~reset;
  end

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_byte(input string name, input cpu_data_t got, input cpu_data_t exp);
    check_count++;
    test_checks++;
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_color(input string name, input color8_t got, input color8_t exp);
    check_count++;
    test_checks++;
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    test_checks++;
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic report_problem(input string msg);
    $display("Error: %s", msg);
    error_count++;
    test_errors++;
  endtask

  // R7 field repeated to 6 bits: 3-bit field times 9, 2-bit field times 21
  function automatic color8_t border_channel(input cpu_data_t fc, input int sel);
    color6_t c6;
    case (sel)
      0:       c6 = color6_t'(fc[4:2]) * 6'd9;
      1:       c6 = color6_t'(fc[7:5]) * 6'd9;
      default: c6 = color6_t'(fc[1:0]) * 6'd21;
    endcase
    return color8_t'(c6) << 2;
  endfunction

  function automatic string test_title(input int n);
    case (n)
      1:       return "register writes and reset state";
      2:       return "vsync interrupt";
      3:       return "hsync line interrupt";
      4:       return "border window";
      5:       return "scanline dimming";
      6:       return "port timing";
      default: return "unnamed";
    endcase
  endfunction

  task automatic finish_test(input int n);
    $display("test %0d %s: %0d checks, %0d errors", n, test_title(n), test_checks, test_errors);
    tests_done++;
    test_checks = 0;
    test_errors = 0;
  endtask

  // --------------------
  // Bus and scan drivers
  // --------------------

  // One port 1 access; ack expected exactly one cycle after req
  task automatic cpu_access(input logic is_wr, input cpu_data_t data, output cpu_data_t rd_data);
    int waited;
    rd_data = '0;
    @(posedge reset);
    #1;
    req  = 1'b1;
    wrt  = is_wr;
    mode = 2'b01;
    dbo  = data;
    @(posedge reset);
    #1;
    req  = 1'b0;
    wrt  = 1'b0;
    mode = 2'b00;
    waited = 1;
    while (!ack && waited < ACK_LIMIT) begin
      @(posedge reset);
      #1;
      waited++;
    end
    if (!ack) begin
      report_problem($sformatf("no ack within %0d cycles of a request", ACK_LIMIT));
    end else begin
      if (waited != 1) begin
        report_problem($sformatf("ack came %0d cycles after the request, not 1", waited));
      end
      rd_data = dbi;
      @(posedge reset);
      #1;
      check_bit("ack", ack, 1'b0);
    end
  endtask

  // cx drops back to 1 after a clock so each event fires once
  task automatic move_scan(input coord_t new_cx, input coord_t new_cy);
    @(posedge reset);
    #1;
    cx = new_cx;
    cy = new_cy;
    @(posedge reset);
    #1;
    cx = 10'd1;
    @(posedge reset);
  endtask

  task automatic run_step(input int idx);
    logic [15:0] op;
    logic [15:0] a0;
    logic [15:0] a1;
    logic [15:0] a2;
    logic [15:0] a3;
    cpu_data_t   rd;
    integer      rnd;
    int          shift;
    op = step_mem[idx*FIELDS+1];
    a0 = step_mem[idx*FIELDS+2];
    a1 = step_mem[idx*FIELDS+3];
    a2 = step_mem[idx*FIELDS+4];
    a3 = step_mem[idx*FIELDS+5];
    case (op)
      16'h0: begin
        cpu_access(1'b1, a0[7:0], rd);
        cpu_access(1'b1, a1[7:0], rd);
        if (a1[7] && (a1[5:0] == REG_FRAME_COL)) begin
          r7_model = a0[7:0];
        end
      end
      16'h1: begin
        cpu_access(1'b0, 8'h00, rd);
        check_byte("dbi", rd, a0[7:0]);
        check_byte("dbi_hold", dbi, a0[7:0]);
      end
      16'h2: move_scan(a0[9:0], a1[9:0]);
      16'h3: begin
        @(posedge reset);
        #1;
        pixel_r  = a0[5:0];
        pixel_g  = a1[5:0];
        pixel_b  = a2[5:0];
        scanline = a3[0];
      end
      16'h4: begin
        @(posedge reset);
        #1;
        check_bit("int_n", int_n, a0[0]);
        check_color("red", red, a1[7:0]);
        check_color("green", green, a2[7:0]);
        check_color("blue", blue, a3[7:0]);
      end
      16'h5: begin
        @(posedge reset);
        #1;
        if (border_channel(r7_model, 0) !== a1[7:0] || border_channel(r7_model, 1) !== a2[7:0] ||
            border_channel(r7_model, 2) !== a3[7:0]) begin
          report_problem($sformatf("testdata border color disagrees with R7 0x%h", r7_model));
        end
        check_color("red", red, a1[7:0]);
        check_color("green", green, a2[7:0]);
        check_color("blue", blue, a3[7:0]);
      end
      16'h6: begin
        @(posedge reset);
        #1;
        rnd = $random(seed);
        pixel_r  = rnd[5:0];
        pixel_g  = rnd[11:6];
        pixel_b  = rnd[17:12];
        scanline = a0[0];
        // Dimmed lines lose one bit of the usual shift by 2
        shift = a1[0] ? 1 : 2;
        @(posedge reset);
        #1;
        check_color("red", red, color8_t'(pixel_r) << shift);
        check_color("green", green, color8_t'(pixel_g) << shift);
        check_color("blue", blue, color8_t'(pixel_b) << shift);
      end
      default: report_problem($sformatf("unknown operation 0x%h in step %0d", op, idx));
    endcase
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    int step;
    int cur_test;
    int t;
    req       = 1'b0;
    wrt       = 1'b0;
    mode      = 2'b00;
    dbo       = '0;
    cx        = 10'd1;
    cy        = '0;
    pixel_r   = '0;
    pixel_g   = '0;
    pixel_b   = '0;
    scanline  = 1'b0;
    clk21m    = 1'b1;
    seed      = 750;
    r7_model  = '0;
    load_done = 1'b0;
    num_steps = 0;
    cur_test  = 0;
    check_count = 0;
    error_count = 0;
    test_checks = 0;
    test_errors = 0;
    tests_done  = 0;
    $readmemh("verif/vdp_testdata.txt", step_mem);
    while (num_steps < MAX_STEPS && (^step_mem[num_steps*FIELDS+1]) !== 1'bx &&
           step_mem[num_steps*FIELDS+1] != 16'hF) begin
      num_steps++;
    end
    if (num_steps == 0) begin
      report_problem("no steps could be read from the testdata file");
    end
    load_done = 1'b1;
    repeat (5) @(posedge reset);
    #1;
    clk21m = 1'b0;
    for (step = 0; step < num_steps; step++) begin
      t = step_mem[step*FIELDS];
      if (t != cur_test) begin
        if (cur_test != 0) begin
          finish_test(cur_test);
        end
        cur_test = t;
      end
      run_step(step);
    end
    if (cur_test != 0) begin
      finish_test(cur_test);
    end
    $display("summary: %0d tests, %0d checks, %0d errors", tests_done, check_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog sized from the number of steps
  initial begin
    wait (load_done === 1'b1);
    repeat ((num_steps + 1) * CYCLES_PER_STEP) @(posedge reset);
    $display("Error: timeout, the run did not end within its cycle budget");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
design/vdp_pkg.sv
design/vdp_frame_timing.sv
design/vdp_registers.sv
design/vdp_interrupt.sv
design/vdp_color_out.sv
design/vdp_top.sv
verif/tb_vdp.sv

// ==== Bender.yml ====
package:
  name: vdp_frame

sources:
  - design/vdp_pkg.sv
  - design/vdp_frame_timing.sv
  - design/vdp_registers.sv
  - design/vdp_interrupt.sv
  - design/vdp_color_out.sv
  - design/vdp_top.sv
  - target: test
    files:
      - verif/tb_vdp.sv

// ==== verif/vdp_testdata.txt ====
// test op a0 a1 a2 a3 in hex; op 0 write bytes a0,a1; 1 read expect a0; 2 scan cx=a0 cy=a1
// op 3 pixel a0-a2 scanline a3; 4 check int_n a0 rgb a1-a3; 5 border check rgb; 6 random pixel, scanline a0, dim a1; F end
1 4 1 0 0 0
1 0 B6 87 0 0
1 5 0 B4 B4 A8
1 0 33 07 0 0
1 5 0 B4 B4 A8
2 0 20 81 0 0
2 2 0 1A8 0 0
2 4 0 B4 B4 A8
2 1 80 0 0 0
2 4 1 B4 B4 A8
2 1 0 0 0 0
2 0 0 81 0 0
2 2 0 1A8 0 0
2 4 1 B4 B4 A8
2 1 80 0 0 0
3 0 5 93 0 0
3 0 10 80 0 0
3 0 1 8F 0 0
3 2 0 28 0 0
3 2 0 32 0 0
3 4 0 0 0 0
3 1 1 0 0 0
3 4 1 0 0 0
3 2 0 34 0 0
3 1 0 0 0 0
4 3 15 2A 3F 0
4 4 1 54 A8 FC
4 2 0 20C 0 0
4 5 0 B4 B4 A8
4 2 0 28 0 0
4 4 1 54 A8 FC
4 0 2 89 0 0
4 2 0 20C 0 0
4 4 1 54 A8 FC
4 2 0 272 0 0
4 5 0 B4 B4 A8
5 2 0 28 0 0
5 2 0 2B 0 0
5 6 1 1 0 0
5 6 1 1 0 0
5 2 0 2C 0 0
5 6 1 0 0 0
5 6 0 0 0 0
6 0 2 8F 0 0
6 1 0 0 0 0
6 1 0 0 0 0
0 F 0 0 0 0
